// ==== rtl/idiv_defs.svh ====
// ====================
// Integer divide shared widths
// Data width, divider iteration count and the poison result
// ====================

`ifndef IDIV_DEFS_SVH
`define IDIV_DEFS_SVH

`default_nettype none

// Width of the dividend, the divisors and the result
`define IDIV_WID 32

// The restoring divider produces one quotient bit per iteration
`define IDIV_CYCLES `IDIV_WID

// Result returned for an opcode the unit does not implement
// The 16-bit pattern repeats to fill the data width
`define IDIV_POISON {(`IDIV_WID/16){16'hdead}}

`default_nettype wire

`endif

// ==== rtl/idiv_pkg.sv ====
// ====================
// Integer divide types
// Opcode and fault cause encodings of the divide unit
// ====================

`default_nettype none

package idiv_pkg;

	// ====================
	// Opcodes
	// ====================

	// Bit 2 picks the remainder over the quotient
	// Bit 0 marks an unsigned operation
	// Codes 2, 3, 6 and 7 are left unimplemented and come back as a bad opcode
	typedef enum logic [2:0]
	{
		DIV_S = 3'd0,
		DIV_U = 3'd1,
		REM_S = 3'd4,
		REM_U = 3'd5
	} div_op_t;

	// ====================
	// Fault causes
	// ====================

	// Reported alongside every result
	// A bad opcode wins over a zero divisor when both apply
	typedef enum logic [1:0]
	{
		CAUSE_NONE  = 2'd0,
		CAUSE_DBZ   = 2'd1,
		CAUSE_BADOP = 2'd2
	} cause_t;

endpackage

`default_nettype wire

// ==== rtl/idiv_issue.sv ====
// ====================
// Integer divide issue latch
// Captures a divide micro-operation on ld and holds it while busy
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module idiv_issue #(
	parameter int WID = `IDIV_WID
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               ld,
	input  idiv_pkg::div_op_t  op,
	input  logic               use_imm,
	input  logic [WID-1:0]     a,
	input  logic [WID-1:0]     b,
	input  logic [WID-1:0]     imm,
	input  logic               done,
	output logic               start,
	output logic               busy,
	output idiv_pkg::div_op_t  lat_op,
	output logic               lat_use_imm,
	output logic [WID-1:0]     lat_a,
	output logic [WID-1:0]     lat_b,
	output logic [WID-1:0]     lat_imm
);

	// A load only counts while the unit is idle, anything else is dropped
	logic accept;

	assign accept = ld && !busy;

	// Start follows the accepted load by one cycle and busy rises with it
	// Busy drops on the edge that samples done, so it is low the cycle after
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start <= 1'b0;
			busy  <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// Operation fields stay frozen for the whole divide
	// The unit decodes lat_op again when the core finishes
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lat_op      <= op;
			lat_use_imm <= use_imm;
			lat_a       <= a;
			lat_b       <= b;
			lat_imm     <= imm;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/div_core.sv ====
// ====================
// Radix-2 restoring divider
// One quotient bit per cycle, sign fix-up and divide-by-zero results
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module div_core #(
	parameter int WID = `IDIV_WID
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           start,
	input  logic           sgn,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	output logic [WID-1:0] q,
	output logic [WID-1:0] r,
	output logic           dbz,
	output logic           core_done
);

	// The load edge runs the first step, RUN the remaining ones, FIX the signs
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_RUN,
		ST_FIX
	} st_t;

	st_t                    st;
	logic [$clog2(WID)-1:0] cnt;
	// Partial remainder, shifting dividend/quotient and divisor magnitude
	logic [WID-1:0]         rem;
	logic [WID-1:0]         quo;
	logic [WID-1:0]         dvs;
	// Original dividend, returned as the remainder of a divide by zero
	logic [WID-1:0]         dvd;
	logic                   neg_q;
	logic                   neg_r;
	logic [WID-1:0]         mag_a;
	logic [WID-1:0]         mag_b;
	logic [2*WID-1:0]       first;
	logic [2*WID-1:0]       next;

	// ====================
	// One restoring step
	// ====================

	// Shift the next dividend bit into the remainder and try the subtract
	// A borrow out of the top bit means the divisor did not fit
	function automatic logic [2*WID-1:0] div_step(
		input logic [WID-1:0] rem_in,
		input logic [WID-1:0] quo_in,
		input logic [WID-1:0] dvs_in
	);
		logic [WID:0]   shifted;
		logic [WID:0]   diff;
		logic [WID-1:0] rem_out;
		logic           qbit;
		shifted = {rem_in, quo_in[WID-1]};
		diff    = shifted - {1'b0, dvs_in};
		if (diff[WID])
		begin
			rem_out = shifted[WID-1:0];
			qbit    = 1'b0;
		end
		else
		begin
			rem_out = diff[WID-1:0];
			qbit    = 1'b1;
		end
		return {rem_out, quo_in[WID-2:0], qbit};
	endfunction

	// Signed operands are divided as magnitudes
	// The most negative value maps onto itself, which is its correct magnitude
	assign mag_a = (sgn && a[WID-1]) ? -a : a;
	assign mag_b = (sgn && b[WID-1]) ? -b : b;

	assign first = div_step('0, mag_a, mag_b);
	assign next  = div_step(rem, quo, dvs);

	// ====================
	// Control
	// ====================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			st        <= ST_IDLE;
			cnt       <= '0;
			dbz       <= 1'b0;
			core_done <= 1'b0;
		end
		else
		begin
			core_done <= 1'b0;
			if (start)
			begin
				// First quotient bit is already taken on this edge
				st  <= ST_RUN;
				cnt <= 1;
				dbz <= (b == '0);
			end
			else
			begin
				case (st)
				ST_RUN:
					begin
						cnt <= cnt + 1'b1;
						// The last of the WID steps hands over to the fix-up
						if (cnt == ($clog2(WID))'(WID - 1))
							st <= ST_FIX;
					end
				ST_FIX:
					begin
						st        <= ST_IDLE;
						core_done <= 1'b1;
					end
				default:
					st <= ST_IDLE;
				endcase
			end
		end
	end

	// ====================
	// Datapath
	// ====================

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			{rem, quo} <= first;
			dvs        <= mag_b;
			dvd        <= a;
			// Quotient is negative when the operand signs differ
			neg_q      <= sgn && (a[WID-1] ^ b[WID-1]);
			// Remainder follows the sign of the dividend
			neg_r      <= sgn && a[WID-1];
		end
		else if (st == ST_RUN)
		begin
			{rem, quo} <= next;
		end
		if (st == ST_FIX)
		begin
			// A zero divisor gives all ones and hands the dividend back
			if (dbz)
			begin
				q <= '1;
				r <= dvd;
			end
			else
			begin
				q <= neg_q ? -quo : quo;
				r <= neg_r ? -rem : rem;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/idiv_unit.sv ====
// ====================
// Integer divide unit
// Picks the divisor, runs the core and returns result, cause and done
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module idiv_unit #(
	parameter int WID = `IDIV_WID
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  idiv_pkg::div_op_t op,
	input  logic              use_imm,
	input  logic [WID-1:0]    a,
	input  logic [WID-1:0]    b,
	input  logic [WID-1:0]    imm,
	output logic [WID-1:0]    o,
	output idiv_pkg::cause_t  cause,
	output logic              done
);

	logic [WID-1:0]   dvs;
	logic             sgn;
	logic [WID-1:0]   core_q;
	logic [WID-1:0]   core_r;
	logic             core_dbz;
	logic             core_done;
	logic [WID-1:0]   res;
	idiv_pkg::cause_t cause_nxt;

	// ====================
	// Operand setup
	// ====================

	// Immediate form replaces the register divisor
	assign dvs = use_imm ? imm : b;

	// Only the two signed opcodes divide as two's complement
	assign sgn = (op == idiv_pkg::DIV_S) || (op == idiv_pkg::REM_S);

	div_core #(
		.WID(WID)
	) div_core_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.sgn       (sgn),
		.a         (a),
		.b         (dvs),
		.q         (core_q),
		.r         (core_r),
		.dbz       (core_dbz),
		.core_done (core_done)
	);

	// ====================
	// Result select
	// ====================

	// The opcode is still held by the issue latch when the core finishes
	// Unknown codes return poison whatever the divisor was
	always_comb
	begin
		res       = WID'(`IDIV_POISON);
		cause_nxt = idiv_pkg::CAUSE_BADOP;
		case (op)
		idiv_pkg::DIV_S, idiv_pkg::DIV_U:
			begin
				res       = core_q;
				cause_nxt = core_dbz ? idiv_pkg::CAUSE_DBZ : idiv_pkg::CAUSE_NONE;
			end
		idiv_pkg::REM_S, idiv_pkg::REM_U:
			begin
				res       = core_r;
				cause_nxt = core_dbz ? idiv_pkg::CAUSE_DBZ : idiv_pkg::CAUSE_NONE;
			end
		default:
			begin
				res       = WID'(`IDIV_POISON);
				cause_nxt = idiv_pkg::CAUSE_BADOP;
			end
		endcase
	end

	// Result and cause load once per divide and hold until the next one
	// Done is the core pulse delayed by one cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			o     <= '0;
			cause <= idiv_pkg::CAUSE_NONE;
			done  <= 1'b0;
		end
		else
		begin
			done <= core_done;
			if (core_done)
			begin
				o     <= res;
				cause <= cause_nxt;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/idiv_top.sv ====
// ====================
// Integer divide top level
// Issue latch feeding the divide unit
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module idiv_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ld,
	input  idiv_pkg::div_op_t     op,
	input  logic                  use_imm,
	input  logic [`IDIV_WID-1:0]  a,
	input  logic [`IDIV_WID-1:0]  b,
	input  logic [`IDIV_WID-1:0]  imm,
	output logic [`IDIV_WID-1:0]  o,
	output idiv_pkg::cause_t      cause,
	output logic                  done,
	output logic                  busy
);

	// Latched operation as seen by the divide unit
	idiv_pkg::div_op_t    lat_op;
	logic                 lat_use_imm;
	logic [`IDIV_WID-1:0] lat_a;
	logic [`IDIV_WID-1:0] lat_b;
	logic [`IDIV_WID-1:0] lat_imm;
	logic                 start;

	idiv_issue #(
		.WID(`IDIV_WID)
	) idiv_issue_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.ld          (ld),
		.op          (op),
		.use_imm     (use_imm),
		.a           (a),
		.b           (b),
		.imm         (imm),
		.done        (done),
		.start       (start),
		.busy        (busy),
		.lat_op      (lat_op),
		.lat_use_imm (lat_use_imm),
		.lat_a       (lat_a),
		.lat_b       (lat_b),
		.lat_imm     (lat_imm)
	);

	// Done also returns to the issue latch to end the busy period
	idiv_unit #(
		.WID(`IDIV_WID)
	) idiv_unit_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.op      (lat_op),
		.use_imm (lat_use_imm),
		.a       (lat_a),
		.b       (lat_b),
		.imm     (lat_imm),
		.o       (o),
		.cause   (cause),
		.done    (done)
	);

endmodule

`default_nettype wire

// ==== bench/idiv_assert.sv ====
// ====================
// Integer divide checker
// Models each accepted divide and asserts on result, cause, timing and busy
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module idiv_assert (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 ld,
	input idiv_pkg::div_op_t    op,
	input logic                 use_imm,
	input logic [`IDIV_WID-1:0] a,
	input logic [`IDIV_WID-1:0] b,
	input logic [`IDIV_WID-1:0] imm,
	input logic [`IDIV_WID-1:0] o,
	input idiv_pkg::cause_t     cause,
	input logic                 done,
	input logic                 busy
);

	logic                 pending;
	int                   cnt;
	logic [`IDIV_WID-1:0] exp_o;
	logic [1:0]           exp_cause;
	logic [`IDIV_WID+1:0] model;

	// Cause on top, result below
	function automatic logic [`IDIV_WID+1:0] model_result(
		input logic [2:0]           code,
		input logic [`IDIV_WID-1:0] x,
		input logic [`IDIV_WID-1:0] y
	);
		logic                 sx;
		logic                 sy;
		logic [`IDIV_WID-1:0] ux;
		logic [`IDIV_WID-1:0] uy;
		sx = !code[0] && x[`IDIV_WID-1];
		sy = !code[0] && y[`IDIV_WID-1];
		ux = sx ? -x : x;
		uy = sy ? -y : y;
		if (code[1])
			return {idiv_pkg::CAUSE_BADOP, `IDIV_POISON};
		else if (y == '0)
			return {idiv_pkg::CAUSE_DBZ, code[2] ? x : {`IDIV_WID{1'b1}}};
		else if (code[2])
			return {idiv_pkg::CAUSE_NONE, sx ? -(ux % uy) : (ux % uy)};
		else
			return {idiv_pkg::CAUSE_NONE, (sx ^ sy) ? -(ux / uy) : (ux / uy)};
	endfunction

	assign model = model_result(op, a, use_imm ? imm : b);

	// Expected values are taken only from a load that the idle unit accepts
	// cnt names the edge, counted from the ld edge, that is sampling
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pending   <= 1'b0;
			cnt       <= 0;
			exp_o     <= '0;
			exp_cause <= '0;
		end
		else if (ld && !busy)
		begin
			pending              <= 1'b1;
			cnt                  <= 1;
			{exp_cause, exp_o}   <= model;
		end
		else if (pending)
		begin
			cnt <= cnt + 1;
			if (done)
				pending <= 1'b0;
		end
	end

	// ====================
	// Assertions
	// ====================

	result_ok: assert property (@(posedge clk) disable iff (!arst_n) done |-> o == exp_o)
	else
	begin
		$error("result o=0x%h but model gives 0x%h", o, exp_o);
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	cause_ok: assert property (@(posedge clk) disable iff (!arst_n) done |-> cause == exp_cause)
	else
	begin
		$error("cause=0x%h but model gives 0x%h", cause, exp_cause);
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	// Exactly one done per accepted load, at edge IDIV_CYCLES + 3
	done_on_time: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> pending && cnt == `IDIV_CYCLES + 3)
	else
	begin
		$error("done came without a divide due at this cycle");
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	done_not_late: assert property (@(posedge clk) disable iff (!arst_n)
		pending && cnt == `IDIV_CYCLES + 3 |-> done)
	else
	begin
		$error("done missing at the expected cycle");
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	busy_ok: assert property (@(posedge clk) disable iff (!arst_n) busy == pending)
	else
	begin
		$error("busy=%0d while a divide pending=%0d", busy, pending);
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	held_ok: assert property (@(posedge clk) disable iff (!arst_n)
		!done |-> $stable(o) && $stable(cause))
	else
	begin
		$error("o or cause changed without done");
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

	// Checked during reset and on the first edge after it
	reset_ok: assert property (@(posedge clk) (!arst_n || !$past(arst_n)) |->
		!done && !busy && o == '0 && cause == idiv_pkg::CAUSE_NONE)
	else
	begin
		$error("outputs not idle around reset");
		idiv_tb.assert_errs = idiv_tb.assert_errs + 1;
	end

endmodule

`default_nettype wire

// ==== bench/idiv_tb.sv ====
// ====================
// Integer divide testbench
// Directed and seeded random divides with checks on value, cause and latency
// ====================

`include "idiv_defs.svh"

`timescale 1ns/10ps
`default_nettype none

module idiv_tb;

	logic                 clk;
	logic                 arst_n;
	logic                 ld;
	idiv_pkg::div_op_t    op;
	logic                 use_imm;
	logic [`IDIV_WID-1:0] a;
	logic [`IDIV_WID-1:0] b;
	logic [`IDIV_WID-1:0] imm;
	logic [`IDIV_WID-1:0] o;
	idiv_pkg::cause_t     cause;
	logic                 done;
	logic                 busy;

	// Value check failures, bound assertion failures and missing completions
	int err_cnt;
	int assert_errs;
	int timeouts;

	idiv_top idiv_top_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ld      (ld),
		.op      (op),
		.use_imm (use_imm),
		.a       (a),
		.b       (b),
		.imm     (imm),
		.o       (o),
		.cause   (cause),
		.done    (done),
		.busy    (busy)
	);

	// The checker sees the top level ports from inside the DUT
	bind idiv_top idiv_assert idiv_assert_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ld      (ld),
		.op      (op),
		.use_imm (use_imm),
		.a       (a),
		.b       (b),
		.imm     (imm),
		.o       (o),
		.cause   (cause),
		.done    (done),
		.busy    (busy)
	);

	// 40 ns clock period
	always #20 clk = ~clk;

	// ====================
	// Expected results
	// ====================

	// Returns the cause in the top two bits and the result below them
	// Magnitudes are divided unsigned so the most negative value needs no special case
	function automatic logic [`IDIV_WID+1:0] reference_div(
		input logic [2:0]           code,
		input logic [`IDIV_WID-1:0] dvd,
		input logic [`IDIV_WID-1:0] dvs
	);
		logic                 sgn;
		logic [`IDIV_WID-1:0] ma;
		logic [`IDIV_WID-1:0] md;
		logic [`IDIV_WID-1:0] q;
		logic [`IDIV_WID-1:0] r;
		sgn = !code[0];
		// Codes 2, 3, 6 and 7 all have bit 1 set and win over a zero divisor
		if (code[1])
			return {idiv_pkg::CAUSE_BADOP, `IDIV_POISON};
		if (dvs == '0)
			return {idiv_pkg::CAUSE_DBZ, code[2] ? dvd : {`IDIV_WID{1'b1}}};
		ma = (sgn && dvd[`IDIV_WID-1]) ? -dvd : dvd;
		md = (sgn && dvs[`IDIV_WID-1]) ? -dvs : dvs;
		q  = ma / md;
		r  = ma % md;
		// Quotient truncates toward zero and the remainder keeps the dividend sign
		if (sgn && (dvd[`IDIV_WID-1] ^ dvs[`IDIV_WID-1]))
			q = -q;
		if (sgn && dvd[`IDIV_WID-1])
			r = -r;
		return {idiv_pkg::CAUSE_NONE, code[2] ? r : q};
	endfunction

	task automatic check_val(
		input string                name,
		input logic [`IDIV_WID-1:0] got,
		input logic [`IDIV_WID-1:0] exp
	);
		assert (got === exp)
		else
		begin
			err_cnt++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Outputs while idle after reset
	task automatic check_idle();
		check_val("done", `IDIV_WID'(done), '0);
		check_val("busy", `IDIV_WID'(busy), '0);
		check_val("o", o, '0);
		check_val("cause", `IDIV_WID'(cause), `IDIV_WID'(idiv_pkg::CAUSE_NONE));
	endtask

	// ====================
	// One divide
	// ====================

	// Pulses ld for one cycle and waits for done
	// With intrude set a second ld with other operands is pulsed mid-divide
	task automatic run_op(
		input logic [2:0]           code,
		input logic                 sel,
		input logic [`IDIV_WID-1:0] av,
		input logic [`IDIV_WID-1:0] bv,
		input logic [`IDIV_WID-1:0] iv,
		input logic                 intrude
	);
		logic [`IDIV_WID+1:0] exp;
		int                   lat;
		@(posedge clk);
		#2;
		ld      = 1'b1;
		op      = idiv_pkg::div_op_t'(code);
		use_imm = sel;
		a       = av;
		b       = bv;
		imm     = iv;
		exp     = reference_div(code, av, sel ? iv : bv);
		@(posedge clk);
		#2;
		ld  = 1'b0;
		// Counts the edge that will sample done with the ld edge as edge 0
		lat = 1;
		while (!done && lat < 100)
		begin
			@(posedge clk);
			#2;
			lat++;
			ld = intrude && (lat == 10);
			if (ld)
			begin
				op      = idiv_pkg::div_op_t'(~code);
				use_imm = !sel;
				a       = ~av;
				b       = bv + 1;
				imm     = iv + 1;
			end
		end
		if (!done)
		begin
			timeouts++;
			$display("Timeout: no done within 100 cycles for opcode %0d", code);
		end
		else
		begin
			check_val("done latency", `IDIV_WID'(lat), `IDIV_WID'(`IDIV_CYCLES + 3));
			check_val("o", o, exp[`IDIV_WID-1:0]);
			check_val("cause", `IDIV_WID'(cause), `IDIV_WID'(exp[`IDIV_WID+1:`IDIV_WID]));
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		logic [`IDIV_WID-1:0] rnd;
		logic [`IDIV_WID-1:0] rav;
		logic [`IDIV_WID-1:0] rbv;
		logic [`IDIV_WID-1:0] riv;
		int                   sh;
		clk         = 1'b0;
		arst_n      = 1'b0;
		ld          = 1'b0;
		op          = idiv_pkg::DIV_S;
		use_imm     = 1'b0;
		a           = '0;
		b           = '0;
		imm         = '0;
		err_cnt     = 0;
		assert_errs = 0;
		timeouts    = 0;
		void'($urandom(32'h91d8_feac));

		repeat (16) @(posedge clk);
		check_idle();
		#2;
		arst_n = 1'b1;
		check_idle();

		// Most negative dividend over minus one wraps to itself with zero remainder
		run_op(idiv_pkg::DIV_S, 1'b0, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0);
		run_op(idiv_pkg::REM_S, 1'b0, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0);
		run_op(idiv_pkg::DIV_S, 1'b0, 32'hffff_fff9, 32'd2, '0, 1'b0);
		run_op(idiv_pkg::REM_S, 1'b0, 32'd7, 32'hffff_fffe, '0, 1'b0);
		run_op(idiv_pkg::DIV_U, 1'b0, 32'hffff_ffff, 32'd3, '0, 1'b0);
		run_op(idiv_pkg::REM_U, 1'b0, 32'h8000_0000, 32'hffff_ffff, '0, 1'b0);

		// Immediate divisor with a zero or conflicting b
		run_op(idiv_pkg::DIV_U, 1'b1, 32'd100, '0, 32'd7, 1'b0);
		run_op(idiv_pkg::REM_S, 1'b1, 32'hffff_ff9c, 32'd5, 32'hffff_fff9, 1'b0);
		run_op(idiv_pkg::DIV_S, 1'b0, 32'd100, 32'd9, '0, 1'b0);

		// Zero divisor from b and then from imm across every opcode
		// Unimplemented codes must still report a bad opcode here
		for (int c = 0; c < 8; c++)
		begin
			run_op(3'(c), 1'b0, 32'h8765_4321, '0, 32'd5, 1'b0);
			run_op(3'(c), 1'b1, 32'h1234_5678, 32'd5, '0, 1'b0);
			if (c[1])
				run_op(3'(c), 1'b0, 32'd1000, 32'd3, '0, 1'b0);
		end

		// A second ld while busy is dropped
		run_op(idiv_pkg::DIV_S, 1'b0, 32'd1000, 32'hffff_fffd, '0, 1'b1);
		run_op(idiv_pkg::REM_U, 1'b1, 32'd1001, '0, 32'd10, 1'b1);

		// Random valid opcodes, operand signs and divisor sizes
		for (int i = 0; i < 200; i++)
		begin
			rnd = $urandom;
			sh  = $urandom_range(31, 0);
			rav = $urandom;
			rbv = $urandom >> sh;
			riv = $urandom >> sh;
			// Half of the divisors are negated so both signs show up often
			if (rnd[3])
			begin
				rbv = -rbv;
				riv = -riv;
			end
			run_op({rnd[1], 1'b0, rnd[0]}, rnd[2], rav, rbv, riv, 1'b0);
		end

		$display("Error counts: checks %0d, assertions %0d, timeouts %0d",
			err_cnt, assert_errs, timeouts);
		if (err_cnt == 0 && assert_errs == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/idiv_pkg.sv
rtl/idiv_issue.sv
rtl/div_core.sv
rtl/idiv_unit.sv
rtl/idiv_top.sv
bench/idiv_assert.sv
bench/idiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the integer divide testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module idiv_tb -o idiv_sim

# A high error limit keeps the run going past failed assertions to the closing line
./obj_dir/idiv_sim +verilator+error+limit+100000 | tee sim.log

if grep -q "sim failed" sim.log
then
	echo "run.sh: failures reported, see sim.log"
	exit 1
fi

echo "run.sh: no failures found in sim.log"
exit 0
